// File: src/ntm_macros.svh
/* Matrix multiplier sizes */

`ifndef NTM_MACROS_SVH
`define NTM_MACROS_SVH

////////////////////////////////////////////////////////////
// Arithmetic widths
////////////////////////////////////////////////////////////

// Signed matrix element
`define NTM_DATA_WIDTH 16

// Dot product accumulator, wraps modulo 2^32
`define NTM_ACC_WIDTH 32

////////////////////////////////////////////////////////////
// Dimensions
////////////////////////////////////////////////////////////

// Loop index and dimension field
`define NTM_DIM_WIDTH 4
// Largest M, K or N
`define NTM_MAX_DIM 8

`endif

// File: src/ntm_data_pkg.sv
/* Matrix data types */

`default_nettype none

`include "ntm_macros.svh"

package ntm_data_pkg;

  // Scalars
  typedef logic signed [`NTM_DATA_WIDTH-1:0] ntm_elem_t;
  typedef logic signed [`NTM_ACC_WIDTH-1:0]  ntm_acc_t;
  typedef logic        [`NTM_DIM_WIDTH-1:0]  ntm_idx_t;

  // Command dimensions, C is m x n, inner length k
  typedef struct packed {
    ntm_idx_t m;
    ntm_idx_t k;
    ntm_idx_t n;
  } ntm_dims_t;

  // One operand pair, A[i][k] and B[k][j]
  typedef struct packed {
    ntm_elem_t a;
    ntm_elem_t b;
  } ntm_pair_t;

  // Finished element with its (i, j) tag
  typedef struct packed {
    ntm_idx_t row;
    ntm_idx_t col;
    ntm_acc_t value;
  } ntm_result_t;

endpackage

`default_nettype wire

// File: src/ntm_ctrl_pkg.sv
/* Matrix control types */

`default_nettype none

package ntm_ctrl_pkg;

  import ntm_data_pkg::*;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    ACCUM,
    EMIT,
    DONE
  } ntm_mm_state_t;

  // Four-phase master phases
  typedef enum logic [1:0] {
    REQ_LOW,
    REQ_HIGH,
    WAIT_ACK_LOW
  } ntm_hs_phase_t;

  // Operand index request
  typedef struct packed {
    ntm_idx_t i;
    ntm_idx_t j;
    ntm_idx_t k;
  } ntm_op_req_t;

endpackage

`default_nettype wire

// File: src/ntm_operand_port.sv
/* Operand fetch port */

`timescale 1ns/10ps
`default_nettype none

module ntm_operand_port
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        fetch,
  input  ntm_op_req_t fetch_idx,
  input  logic        op_ack,
  input  ntm_pair_t   op_data,
  output logic        op_req,
  output ntm_op_req_t op_idx,
  output logic        pair_valid,
  output ntm_pair_t   pair
);

  ntm_hs_phase_t phase;
  // Fetch seen while the previous ack is still high
  logic          fetch_pend;

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase      <= REQ_LOW;
      op_req     <= 1'b0;
      pair_valid <= 1'b0;
      fetch_pend <= 1'b0;
    end else begin
      pair_valid <= 1'b0;
      if (fetch) begin
        fetch_pend <= 1'b1;
      end
      case (phase)
        REQ_LOW: begin
          // Index already registered, safe to raise req
          if (fetch_pend) begin
            op_req     <= 1'b1;
            fetch_pend <= fetch;
            phase      <= REQ_HIGH;
          end
        end
        REQ_HIGH: begin
          if (op_ack) begin
            op_req     <= 1'b0;
            pair_valid <= 1'b1;
            phase      <= WAIT_ACK_LOW;
          end
        end
        WAIT_ACK_LOW: begin
          if (!op_ack) begin
            phase <= REQ_LOW;
          end
        end
        default: phase <= REQ_LOW;
      endcase
    end
  end

  // Index and reply registers
  always_ff @(posedge CLK) begin
    if (fetch) begin
      op_idx <= fetch_idx;
    end
    // Memory data valid only while ack is high
    if (phase == REQ_HIGH && op_ack) begin
      pair <= op_data;
    end
  end

endmodule

`default_nettype wire

// File: src/ntm_dot_product.sv
/* Dot product MAC */

`timescale 1ns/10ps
`default_nettype none

module ntm_dot_product
  import ntm_data_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      acc_start,
  input  ntm_idx_t  k_count,
  input  logic      pair_valid,
  input  ntm_pair_t pair,
  output logic      acc_ready,
  output ntm_acc_t  acc_value
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Pairs taken since the last start
  ntm_idx_t pair_cnt;
  // Sign-extended product of the current pair
  ntm_acc_t product;
  // Running sum
  ntm_acc_t acc;
  logic     last_pair;

  ////////////////////////////////////////////////////////////
  // Multiply
  ////////////////////////////////////////////////////////////

  // Both operands signed, so they extend to 32 bits first
  always_comb begin
    product = pair.a * pair.b;
  end

  assign last_pair = (pair_cnt + 1'b1 == k_count);

  ////////////////////////////////////////////////////////////
  // Pair counter and ready flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pair_cnt  <= '0;
      acc_ready <= 1'b0;
    end else if (acc_start) begin
      pair_cnt  <= '0;
      acc_ready <= 1'b0;
    end else if (pair_valid && !acc_ready) begin
      pair_cnt <= pair_cnt + 1'b1;
      // Ready shows one cycle after the K-th pair
      if (last_pair) begin
        acc_ready <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////

  // Wraps modulo 2^32, no saturation
  always_ff @(posedge CLK) begin
    if (acc_start) begin
      acc <= '0;
    end else if (pair_valid && !acc_ready) begin
      acc <= acc + product;
    end
  end

  // Held until the next start
  assign acc_value = acc;

endmodule

`default_nettype wire

// File: src/ntm_result_port.sv
/* Result delivery port */

`timescale 1ns/10ps
`default_nettype none

module ntm_result_port
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        emit,
  input  ntm_result_t emit_data,
  input  logic        res_ack,
  output logic        res_req,
  output ntm_result_t res_data,
  output logic        emit_done
);

  ntm_hs_phase_t phase;

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase     <= REQ_LOW;
      res_req   <= 1'b0;
      emit_done <= 1'b0;
    end else begin
      emit_done <= 1'b0;
      case (phase)
        REQ_LOW: begin
          if (emit) begin
            res_req <= 1'b1;
            phase   <= REQ_HIGH;
          end
        end
        REQ_HIGH: begin
          // Consumer has taken the element
          if (res_ack) begin
            res_req <= 1'b0;
            phase   <= WAIT_ACK_LOW;
          end
        end
        WAIT_ACK_LOW: begin
          if (!res_ack) begin
            emit_done <= 1'b1;
            phase     <= REQ_LOW;
          end
        end
        default: phase <= REQ_LOW;
      endcase
    end
  end

  // Held stable through the whole handshake
  always_ff @(posedge CLK) begin
    if (emit && phase == REQ_LOW) begin
      res_data <= emit_data;
    end
  end

endmodule

`default_nettype wire

// File: src/ntm_matrix_multiplier.sv
/* Matrix multiplier controller */

`timescale 1ns/10ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_matrix_multiplier
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        cmd_req,
  input  ntm_dims_t   cmd_dims,
  input  logic        op_ack,
  input  ntm_pair_t   op_data,
  input  logic        res_ack,
  output logic        cmd_ack,
  output logic        op_req,
  output ntm_op_req_t op_idx,
  output logic        res_req,
  output ntm_result_t res_data
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  ntm_mm_state_t state;
  ntm_dims_t     dims;
  ntm_idx_t      i_idx;
  ntm_idx_t      j_idx;
  ntm_idx_t      k_idx;
  logic          last_i;
  logic          last_j;
  logic          last_k;

  // Operand port side
  logic          fetch;
  ntm_op_req_t   fetch_idx;
  logic          pair_valid;
  ntm_pair_t     pair;

  // Dot product side
  logic          acc_start;
  logic          acc_ready;
  ntm_acc_t      acc_value;

  // Result port side
  logic          emit;
  logic          emit_done;
  ntm_result_t   emit_data;

  // 0 runs as 1, anything past the maximum is clipped
  function automatic ntm_idx_t fix_dim(input ntm_idx_t d);
    if (d == '0) begin
      return ntm_idx_t'(1);
    end
    if (d > ntm_idx_t'(`NTM_MAX_DIM)) begin
      return ntm_idx_t'(`NTM_MAX_DIM);
    end
    return d;
  endfunction

  assign last_i = (i_idx == dims.m - 1'b1);
  assign last_j = (j_idx == dims.n - 1'b1);
  assign last_k = (k_idx == dims.k - 1'b1);

  ////////////////////////////////////////////////////////////
  // Loop FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      dims      <= '0;
      i_idx     <= '0;
      j_idx     <= '0;
      k_idx     <= '0;
      fetch     <= 1'b0;
      fetch_idx <= '0;
      acc_start <= 1'b0;
      emit      <= 1'b0;
      emit_data <= '0;
      cmd_ack   <= 1'b0;
    end else begin
      // Pulses by default
      fetch     <= 1'b0;
      acc_start <= 1'b0;
      emit      <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_req) begin
            dims.m    <= fix_dim(cmd_dims.m);
            dims.k    <= fix_dim(cmd_dims.k);
            dims.n    <= fix_dim(cmd_dims.n);
            i_idx     <= '0;
            j_idx     <= '0;
            k_idx     <= '0;
            fetch_idx <= '0;
            fetch     <= 1'b1;
            acc_start <= 1'b1;
            state     <= FETCH;
          end
        end
        FETCH: begin
          // One pair in flight, next k once it lands
          if (pair_valid) begin
            if (last_k) begin
              state <= ACCUM;
            end else begin
              k_idx       <= k_idx + 1'b1;
              fetch_idx.i <= i_idx;
              fetch_idx.j <= j_idx;
              fetch_idx.k <= k_idx + 1'b1;
              fetch       <= 1'b1;
            end
          end
        end
        ACCUM: begin
          if (acc_ready) begin
            emit_data.row   <= i_idx;
            emit_data.col   <= j_idx;
            emit_data.value <= acc_value;
            emit            <= 1'b1;
            state           <= EMIT;
          end
        end
        EMIT: begin
          // Row-major, j fastest
          if (emit_done) begin
            if (last_i && last_j) begin
              cmd_ack <= 1'b1;
              state   <= DONE;
            end else begin
              k_idx       <= '0;
              fetch_idx.k <= '0;
              fetch       <= 1'b1;
              acc_start   <= 1'b1;
              state       <= FETCH;
              if (last_j) begin
                i_idx       <= i_idx + 1'b1;
                j_idx       <= '0;
                fetch_idx.i <= i_idx + 1'b1;
                fetch_idx.j <= '0;
              end else begin
                j_idx       <= j_idx + 1'b1;
                fetch_idx.i <= i_idx;
                fetch_idx.j <= j_idx + 1'b1;
              end
            end
          end
        end
        DONE: begin
          // Host closes the command handshake
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath blocks
  ////////////////////////////////////////////////////////////

  ntm_operand_port ntm_operand_port_i (
    .CLK        (CLK),
    .RST        (RST),
    .fetch      (fetch),
    .fetch_idx  (fetch_idx),
    .op_ack     (op_ack),
    .op_data    (op_data),
    .op_req     (op_req),
    .op_idx     (op_idx),
    .pair_valid (pair_valid),
    .pair       (pair)
  );

  // Pairs go straight on, pair_valid is already one cycle
  ntm_dot_product ntm_dot_product_i (
    .CLK        (CLK),
    .RST        (RST),
    .acc_start  (acc_start),
    .k_count    (dims.k),
    .pair_valid (pair_valid),
    .pair       (pair),
    .acc_ready  (acc_ready),
    .acc_value  (acc_value)
  );

  ntm_result_port ntm_result_port_i (
    .CLK       (CLK),
    .RST       (RST),
    .emit      (emit),
    .emit_data (emit_data),
    .res_ack   (res_ack),
    .res_req   (res_req),
    .res_data  (res_data),
    .emit_done (emit_done)
  );

endmodule

`default_nettype wire

// File: src/ntm_matrix_top.sv
/* Matrix multiplier top */

`timescale 1ns/10ps
`default_nettype none

module ntm_matrix_top
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  // Command port
  input  logic        cmd_req,
  input  ntm_dims_t   cmd_dims,
  output logic        cmd_ack,
  // Operand memory port
  input  logic        op_ack,
  input  ntm_pair_t   op_data,
  output logic        op_req,
  output ntm_op_req_t op_idx,
  // Result port
  input  logic        res_ack,
  output logic        res_req,
  output ntm_result_t res_data
);

  // Single compute tile
  ntm_matrix_multiplier ntm_matrix_multiplier_i (
    .CLK      (CLK),
    .RST      (RST),
    .cmd_req  (cmd_req),
    .cmd_dims (cmd_dims),
    .op_ack   (op_ack),
    .op_data  (op_data),
    .res_ack  (res_ack),
    .cmd_ack  (cmd_ack),
    .op_req   (op_req),
    .op_idx   (op_idx),
    .res_req  (res_req),
    .res_data (res_data)
  );

endmodule

`default_nettype wire

// File: tests/ntm_matrix_checker.sv
/* Matrix result checker */

`timescale 1ns/10ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_matrix_checker
  import ntm_data_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        cmd_req,
  input  ntm_dims_t   cmd_dims,
  input  logic        cmd_ack,
  input  logic        res_req,
  input  logic        res_ack,
  input  ntm_result_t res_data,
  input  ntm_elem_t [`NTM_MAX_DIM*`NTM_MAX_DIM-1:0] mat_a,
  input  ntm_elem_t [`NTM_MAX_DIM*`NTM_MAX_DIM-1:0] mat_b,
  output int          test_count,
  output int          result_count,
  output int          error_count
);

  // Effective dimensions of the running command
  int   m_len;
  int   k_len;
  int   n_len;
  // Next tag due, row-major
  int   exp_row;
  int   exp_col;
  int   test_results;
  int   test_first_error;
  int   expected;
  logic active;
  logic res_req_q;
  logic cmd_req_q;
  logic cmd_ack_q;

  // Zero dimension runs as 1
  function automatic int effective_dim(input ntm_idx_t d);
    return (d == 0) ? 1 : int'(d);
  endfunction

  // Reference dot product, int arithmetic wraps modulo 2^32
  function automatic int model_product(input int row, input int col, input int len);
    int sum;
    sum = 0;
    for (int k = 0; k < len; k++) begin
      sum = sum + int'(mat_a[row*`NTM_MAX_DIM + k]) * int'(mat_b[k*`NTM_MAX_DIM + col]);
    end
    return sum;
  endfunction

  initial begin
    test_count   = 0;
    result_count = 0;
    error_count  = 0;
    active       = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // Port monitor
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (RST) begin
      res_req_q = 1'b0;
      cmd_req_q = 1'b0;
      cmd_ack_q = 1'b0;
    end else begin
      // New command
      if (cmd_req && !cmd_req_q) begin
        m_len            = effective_dim(cmd_dims.m);
        k_len            = effective_dim(cmd_dims.k);
        n_len            = effective_dim(cmd_dims.n);
        exp_row          = 0;
        exp_col          = 0;
        test_results     = 0;
        test_first_error = error_count;
        active           = 1'b1;
      end
      // Result offered, data already stable with req
      if (res_req && !res_req_q) begin
        if (!active) begin
          $display("error at %0t: result arrived with no command running", $time);
          error_count++;
        end else if (test_results >= m_len * n_len) begin
          $display("error at %0t: result beyond the %0d expected", $time, m_len * n_len);
          error_count++;
        end else begin
          if (res_data.row != exp_row || res_data.col != exp_col) begin
            $display("error at %0t: result tag (%0d,%0d) out of order, expected (%0d,%0d)",
                     $time, res_data.row, res_data.col, exp_row, exp_col);
            error_count++;
          end
          expected = model_product(exp_row, exp_col, k_len);
          if (res_data.value !== expected) begin
            $display("mismatch at %0t: C[%0d][%0d] = %0d, expected %0d",
                     $time, exp_row, exp_col, res_data.value, expected);
            error_count++;
          end
          // j fastest
          exp_col++;
          if (exp_col == n_len) begin
            exp_col = 0;
            exp_row++;
          end
        end
        test_results++;
        result_count++;
      end
      // Command complete
      if (cmd_ack && !cmd_ack_q) begin
        if (test_results != m_len * n_len) begin
          $display("error at %0t: command acknowledged after %0d results, expected %0d",
                   $time, test_results, m_len * n_len);
          error_count++;
        end
        if (res_req || res_ack) begin
          $display("error at %0t: command acknowledged during a result handshake", $time);
          error_count++;
        end
        $display("test %0d: M=%0d K=%0d N=%0d, %0d results, %0d errors", test_count,
                 m_len, k_len, n_len, test_results, error_count - test_first_error);
        test_count++;
        active = 1'b0;
      end
      if (cmd_ack_q && !cmd_ack && cmd_req) begin
        $display("error at %0t: cmd_ack fell while cmd_req was still high", $time);
        error_count++;
      end
      res_req_q = res_req;
      cmd_req_q = cmd_req;
      cmd_ack_q = cmd_ack;
    end
  end

endmodule

`default_nettype wire

// File: tests/ntm_matrix_tb.sv
/* Matrix multiplier testbench */

`timescale 1ns/10ps
`default_nettype none

`include "ntm_macros.svh"

module ntm_matrix_tb
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
();

  localparam int NUM_TESTS   = 12;
  localparam int ELEMS       = `NTM_MAX_DIM * `NTM_MAX_DIM;
  // Worst case per test, 40 cycles of 20 ns per MAC slot
  localparam int WATCHDOG_NS = NUM_TESTS * ELEMS * `NTM_MAX_DIM * 40 * 20;

  logic        CLK;
  logic        RST;
  logic        cmd_req;
  ntm_dims_t   cmd_dims;
  logic        cmd_ack;
  logic        op_ack;
  ntm_pair_t   op_data;
  logic        op_req;
  ntm_op_req_t op_idx;
  logic        res_ack;
  logic        res_req;
  ntm_result_t res_data;

  // Row-major operand matrices, row * MAX_DIM + col
  ntm_elem_t [ELEMS-1:0] mat_a;
  ntm_elem_t [ELEMS-1:0] mat_b;
  int seed;
  int test_count;
  int result_count;
  int error_count;

  ntm_matrix_top ntm_matrix_top_i (
    .CLK      (CLK),
    .RST      (RST),
    .cmd_req  (cmd_req),
    .cmd_dims (cmd_dims),
    .cmd_ack  (cmd_ack),
    .op_ack   (op_ack),
    .op_data  (op_data),
    .op_req   (op_req),
    .op_idx   (op_idx),
    .res_ack  (res_ack),
    .res_req  (res_req),
    .res_data (res_data)
  );

  ntm_matrix_checker ntm_matrix_checker_i (
    .CLK          (CLK),
    .RST          (RST),
    .cmd_req      (cmd_req),
    .cmd_dims     (cmd_dims),
    .cmd_ack      (cmd_ack),
    .res_req      (res_req),
    .res_ack      (res_ack),
    .res_data     (res_data),
    .mat_a        (mat_a),
    .mat_b        (mat_b),
    .test_count   (test_count),
    .result_count (result_count),
    .error_count  (error_count)
  );

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic ntm_idx_t random_dim();
    return ntm_idx_t'(1 + $unsigned($random(seed)) % `NTM_MAX_DIM);
  endfunction

  // Extreme fill puts -32768 everywhere
  task automatic fill_matrices(input logic extreme);
    for (int e = 0; e < ELEMS; e++) begin
      if (extreme) begin
        mat_a[e] = 16'sh8000;
        mat_b[e] = 16'sh8000;
      end else begin
        mat_a[e] = ntm_elem_t'($random(seed) ^ e);
        mat_b[e] = ntm_elem_t'($random(seed) + e);
      end
    end
  endtask

  // Full four-phase command, dims held until ack
  task automatic run_command(input ntm_idx_t m, input ntm_idx_t k, input ntm_idx_t n);
    @(posedge CLK);
    cmd_dims <= {m, k, n};
    cmd_req  <= 1'b1;
    @(posedge CLK);
    while (!cmd_ack) @(posedge CLK);
    cmd_req <= 1'b0;
    @(posedge CLK);
    while (cmd_ack) @(posedge CLK);
  endtask

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed     = 67;
    RST      = 1'b1;
    cmd_req  = 1'b0;
    cmd_dims = '0;
    op_ack   = 1'b0;
    op_data  = '0;
    res_ack  = 1'b0;
    mat_a    = '0;
    mat_b    = '0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    // Eight products of 2^30 wrap to zero
    fill_matrices(1'b1);
    run_command(4'd2, 4'd8, 4'd2);
    // Zero dimensions
    fill_matrices(1'b0);
    run_command(4'd0, 4'd0, 4'd0);
    fill_matrices(1'b0);
    run_command(4'd3, 4'd0, 4'd2);
    for (int t = 3; t < NUM_TESTS; t++) begin
      fill_matrices(1'b0);
      run_command(random_dim(), random_dim(), random_dim());
    end
    repeat (5) @(posedge CLK);
    if (test_count != NUM_TESTS) begin
      $display("error: %0d commands completed, expected %0d", test_count, NUM_TESTS);
    end
    $display("tests %0d, results %0d, errors %0d", test_count, result_count, error_count);
    if (error_count == 0 && test_count == NUM_TESTS) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Responders
  ////////////////////////////////////////////////////////////

  // Operand memory, 0 to 3 cycles before ack
  initial begin : memory_responder
    int delay;
    forever begin
      @(posedge CLK);
      if (op_req && !op_ack) begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge CLK);
        op_data.a <= mat_a[op_idx.i * `NTM_MAX_DIM + op_idx.k];
        op_data.b <= mat_b[op_idx.k * `NTM_MAX_DIM + op_idx.j];
        op_ack    <= 1'b1;
        @(posedge CLK);
        while (op_req) @(posedge CLK);
        op_ack <= 1'b0;
      end
    end
  end

  // Result consumer, 0 to 4 cycles before ack
  initial begin : result_consumer
    int delay;
    forever begin
      @(posedge CLK);
      if (res_req && !res_ack) begin
        delay = $unsigned($random(seed)) % 5;
        repeat (delay) @(posedge CLK);
        res_ack <= 1'b1;
        @(posedge CLK);
        while (res_req) @(posedge CLK);
        res_ack <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
src/ntm_data_pkg.sv
src/ntm_ctrl_pkg.sv
src/ntm_operand_port.sv
src/ntm_dot_product.sv
src/ntm_result_port.sv
src/ntm_matrix_multiplier.sv
src/ntm_matrix_top.sv
tests/ntm_matrix_checker.sv
tests/ntm_matrix_tb.sv
